//--- include/aes_settings.svh
/*
 * AES-128 sizes, fixed by the standard; changing them breaks the cipher.
 */
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// one block is sixteen bytes
`define AES_BLOCK_BITS  128
`define AES_BYTE_BITS   8
`define AES_BLOCK_BYTES 16

// AES-128 round count
`define AES_ROUNDS      10

`endif

//--- hdl/aesTypesPkg.sv
/*
 * Data types of the byte-stream encryptor.
 * Byte 0 of a block is its most significant byte.
 */
`default_nettype none

`include "aes_settings.svh"

package aesTypesPkg;

    typedef logic [`AES_BLOCK_BITS-1:0] block_t;
    typedef logic [`AES_BYTE_BITS-1:0] byte_t;

    // position of a byte inside a block, 0 to 15
    typedef logic [$clog2(`AES_BLOCK_BYTES)-1:0] byteIndex_t;

    // engine FSM
    typedef enum logic [1:0] {
        IDLE,
        ROUND,
        HOLD
    } engineState_t;

endpackage

`default_nettype wire

//--- hdl/aesCipherPkg.sv
/*
 * AES forward transforms on a whole block, standard state layout:
 * byte k sits at row k mod 4, column k div 4, byte 0 most significant.
 */
`default_nettype none

`include "aes_settings.svh"

package aesCipherPkg;
    import aesTypesPkg::*;

    // forward S-box, entry 0 in the top byte
    localparam logic [0:255][`AES_BYTE_BITS-1:0] SBOX = {
        128'h637c777bf26b6fc53001672bfed7ab76, 128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115, 128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84, 128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8, 128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973, 128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479, 128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a, 128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df, 128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic byte_t sboxByte(byte_t b);
        return SBOX[b];
    endfunction

    // multiply by 2 in GF(2^8)
    function automatic byte_t xtime(byte_t b);
        return {b[`AES_BYTE_BITS-2:0], 1'b0} ^ (b[`AES_BYTE_BITS-1] ? 8'h1b : 8'h00);
    endfunction

    function automatic block_t subBlock(block_t b);
        byte_t [0:`AES_BLOCK_BYTES-1] s;
        s = b;
        for (int k = 0; k < `AES_BLOCK_BYTES; k++) begin
            s[k] = sboxByte(s[k]);
        end
        return s;
    endfunction

    // row r rotates left by r columns
    function automatic block_t shiftBlock(block_t b);
        byte_t [0:`AES_BLOCK_BYTES-1] s;
        byte_t [0:`AES_BLOCK_BYTES-1] t;
        int r;
        int c;
        s = b;
        for (int k = 0; k < `AES_BLOCK_BYTES; k++) begin
            r = k % 4;
            c = k / 4;
            t[k] = s[r + 4 * ((c + r) % 4)];
        end
        return t;
    endfunction

    // each column times the circulant 2 3 1 1
    function automatic block_t mixBlock(block_t b);
        byte_t [0:`AES_BLOCK_BYTES-1] s;
        byte_t [0:`AES_BLOCK_BYTES-1] t;
        byte_t a1;
        s = b;
        for (int c = 0; c < 4; c++) begin
            for (int i = 0; i < 4; i++) begin
                a1 = s[4 * c + (i + 1) % 4];
                t[4 * c + i] = xtime(s[4 * c + i]) ^ xtime(a1) ^ a1
                    ^ s[4 * c + (i + 2) % 4] ^ s[4 * c + (i + 3) % 4];
            end
        end
        return t;
    endfunction

endpackage

`default_nettype wire

//--- hdl/blockIf.sv
/*
 * Buffer-to-engine link. take is a one-cycle pulse and is legal only
 * while full is high; the buffer drops full in the following cycle.
 */
`timescale 1ns/1ps
`default_nettype none

interface blockIf;
    import aesTypesPkg::*;

    logic full;
    block_t block;
    logic take;

    modport source (
        output full,
        output block,
        input  take
    );

    modport sink (
        input  full,
        input  block,
        output take
    );

endinterface

`default_nettype wire

//--- hdl/bytePacker.sv
/*
 * Packs sixteen bytes into one block, first byte most significant.
 * inClk while upstreamReadClk is low is a protocol error and is dropped.
 */
`timescale 1ns/1ps
`default_nettype none

`include "aes_settings.svh"

module bytePacker (
    input  logic                clk,
    input  logic                rst,
    input  logic                inClk,
    input  aesTypesPkg::byte_t  inByte,
    input  logic                blockFull,
    output logic                write,
    output aesTypesPkg::block_t packedBlock,
    output logic                upstreamReadClk
);
    import aesTypesPkg::*;

    byteIndex_t count;
    logic holding;

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
            holding <= 1'b0;
        end else begin
            if (inClk && !holding) begin
                count <= count + 1'b1;
                // last byte completes the block, count wraps to zero
                if (count == byteIndex_t'(`AES_BLOCK_BYTES - 1)) begin
                    holding <= 1'b1;
                end
            end else if (write) begin
                holding <= 1'b0;
            end
        end
    end

    // shift register for the payload
    always_ff @(posedge clk) begin
        if (inClk && !holding) begin
            packedBlock <= {packedBlock[`AES_BLOCK_BITS-`AES_BYTE_BITS-1:0], inByte};
        end
    end

    assign write = holding && !blockFull;
    assign upstreamReadClk = !holding;

endmodule

`default_nettype wire

//--- hdl/blockBuffer.sv
/*
 * One-block buffer between packer and engine.
 * Writes while full are not expected; the packer checks full first.
 */
`timescale 1ns/1ps
`default_nettype none

module blockBuffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                write,
    input  aesTypesPkg::block_t packedBlock,
    output logic                full,
    blockIf.source              bus
);
    import aesTypesPkg::*;

    block_t blockReg;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (write) begin
            full <= 1'b1;
        end else if (bus.take) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            blockReg <= packedBlock;
        end
    end

    assign bus.full = full;
    assign bus.block = blockReg;

endmodule

`default_nettype wire

//--- hdl/cipherEngine.sv
/*
 * Iterative AES-128 encryption, one round per clock, same key every round.
 * key is latched when the block is taken; the result appears 10 cycles later.
 */
`timescale 1ns/1ps
`default_nettype none

`include "aes_settings.svh"

module cipherEngine (
    input  logic                clk,
    input  logic                rst,
    input  aesTypesPkg::block_t key,
    blockIf.sink                bus,
    input  logic                serialBusy,
    output logic                load,
    output aesTypesPkg::block_t result
);
    import aesTypesPkg::*;
    import aesCipherPkg::*;

    engineState_t state;
    logic [3:0] round;
    block_t stateBlk;
    block_t keyReg;
    block_t shifted;
    block_t roundOut;
    logic take;
    logic lastRound;

    assign lastRound = (round == 4'(`AES_ROUNDS));

    // one round of combinational logic, no mix in the final round
    always_comb begin
        shifted = shiftBlock(subBlock(stateBlk));
        if (lastRound) begin
            roundOut = shifted ^ keyReg;
        end else begin
            roundOut = mixBlock(shifted) ^ keyReg;
        end
    end

    assign take = (state == IDLE) && bus.full;
    assign bus.take = take;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            round <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        round <= 4'd1;
                        state <= ROUND;
                    end
                end
                ROUND: begin
                    if (!lastRound) begin
                        round <= round + 1'b1;
                    end else if (serialBusy) begin
                        state <= HOLD;
                    end else begin
                        state <= IDLE;
                    end
                end
                HOLD: begin
                    if (!serialBusy) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // initial key add on take, then the round result each cycle
    always_ff @(posedge clk) begin
        if (take) begin
            stateBlk <= bus.block ^ key;
            keyReg <= key;
        end else if (state == ROUND) begin
            stateBlk <= roundOut;
        end
    end

    assign load = !serialBusy && ((state == HOLD) || (state == ROUND && lastRound));
    assign result = (state == HOLD) ? stateBlk : roundOut;

endmodule

`default_nettype wire

//--- hdl/byteSerializer.sv
/*
 * Sends a finished block out as sixteen bytes, most significant first.
 * outByte is valid only in the cycle where outClk is high.
 */
`timescale 1ns/1ps
`default_nettype none

`include "aes_settings.svh"

module byteSerializer (
    input  logic                clk,
    input  logic                rst,
    input  logic                load,
    input  aesTypesPkg::block_t result,
    input  logic                readClk,
    output logic                busy,
    output logic                outClk,
    output aesTypesPkg::byte_t  outByte
);
    import aesTypesPkg::*;

    block_t blockReg;
    byteIndex_t count;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            outClk <= 1'b0;
            count <= '0;
        end else begin
            // reads while idle are ignored
            outClk <= readClk && busy;
            if (load) begin
                busy <= 1'b1;
                count <= '0;
            end else if (readClk && busy) begin
                count <= count + 1'b1;
                if (count == byteIndex_t'(`AES_BLOCK_BYTES - 1)) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            blockReg <= result;
        end else if (readClk && busy) begin
            outByte <= blockReg[`AES_BLOCK_BITS-1 -: `AES_BYTE_BITS];
            blockReg <= blockReg << `AES_BYTE_BITS;
        end
    end

endmodule

`default_nettype wire

//--- hdl/aesByteStream.sv
/*
 * AES-128 byte-stream encryptor, whole blocks only, no key schedule.
 * key must stay stable from a block's first byte until the engine takes it.
 */
`timescale 1ns/1ps
`default_nettype none

module aesByteStream (
    input  logic                clk,
    input  logic                rst,
    input  logic                inClk,
    input  aesTypesPkg::byte_t  inByte,
    input  aesTypesPkg::block_t key,
    output logic                upstreamReadClk,
    input  logic                readClk,
    output logic                outClk,
    output aesTypesPkg::byte_t  outByte
);
    import aesTypesPkg::*;

    logic blockFull;
    logic write;
    block_t packedBlock;
    logic load;
    logic serialBusy;
    block_t result;

    blockIf bus ();

    bytePacker packer_i (
        .clk             (clk),
        .rst             (rst),
        .inClk           (inClk),
        .inByte          (inByte),
        .blockFull       (blockFull),
        .write           (write),
        .packedBlock     (packedBlock),
        .upstreamReadClk (upstreamReadClk)
    );

    blockBuffer buffer_i (
        .clk         (clk),
        .rst         (rst),
        .write       (write),
        .packedBlock (packedBlock),
        .full        (blockFull),
        .bus         (bus.source)
    );

    cipherEngine engine_i (
        .clk        (clk),
        .rst        (rst),
        .key        (key),
        .bus        (bus.sink),
        .serialBusy (serialBusy),
        .load       (load),
        .result     (result)
    );

    byteSerializer serializer_i (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .result  (result),
        .readClk (readClk),
        .busy    (serialBusy),
        .outClk  (outClk),
        .outByte (outByte)
    );

endmodule

`default_nettype wire

//--- bench/aesByteStream_chk.sv
/*
 * Strobe protocol assertions on the top level, attached by bind.
 */
`timescale 1ns/1ps
`default_nettype none

module aesByteStream_chk (
    input logic clk,
    input logic rst,
    input logic inClk,
    input logic upstreamReadClk,
    input logic readClk,
    input logic outClk
);

    // every output byte answers a read of the previous cycle
    outAfterRead: assert property (@(posedge clk) disable iff (rst) outClk |-> $past(readClk))
        else $error("outClk high without a readClk in the previous cycle");

    inWhileReady: assert property (@(posedge clk) disable iff (rst) inClk |-> upstreamReadClk)
        else $error("inClk high while upstreamReadClk is low");

    // first cycle out of reset is quiet
    quietAfterReset: assert property (@(posedge clk) $past(rst) |-> !outClk)
        else $error("outClk high in the cycle after reset");

endmodule

bind aesByteStream aesByteStream_chk chk_i (
    .clk             (clk),
    .rst             (rst),
    .inClk           (inClk),
    .upstreamReadClk (upstreamReadClk),
    .readClk         (readClk),
    .outClk          (outClk)
);

`default_nettype wire

//--- bench/aesByteStreamTb.sv
/*
 * Drives whole blocks into the encryptor and checks every output byte
 * against a model of the cipher. Inputs change 1 ns after the rising edge.
 */
`timescale 1ns/1ps
`default_nettype none

`include "aes_settings.svh"

module aesByteStreamTb;
    import aesTypesPkg::*;
    import aesCipherPkg::*;

    // 1 fixed + 20 streamed + 8 under back-pressure + 3 with key changes
    localparam int NUM_BLOCKS = 32;
    // input bytes, engine cycles, reads at one per two cycles
    localparam int BLOCK_CYCLES = `AES_BLOCK_BYTES + `AES_ROUNDS + 1 + 2 * `AES_BLOCK_BYTES;
    localparam int CYCLE_LIMIT = NUM_BLOCKS * BLOCK_CYCLES + 2000;

    logic clk;
    logic rst;
    logic inClk;
    byte_t inByte;
    block_t key;
    logic upstreamReadClk;
    logic readClk;
    logic outClk;
    byte_t outByte;

    logic [1:0] readMode;
    byte_t expQ[$];
    int cycles;
    int stallRun;
    int maxStall;

    aesByteStream dut_i (
        .clk             (clk),
        .rst             (rst),
        .inClk           (inClk),
        .inByte          (inByte),
        .key             (key),
        .upstreamReadClk (upstreamReadClk),
        .readClk         (readClk),
        .outClk          (outClk),
        .outByte         (outByte)
    );

    always #50 clk = ~clk;

    // initial key add, nine full rounds, last round without mix
    function automatic block_t aesRef(block_t plain, block_t blkKey);
        block_t s;
        s = plain ^ blkKey;
        for (int r = 1; r < `AES_ROUNDS; r++) begin
            s = mixBlock(shiftBlock(subBlock(s))) ^ blkKey;
        end
        return shiftBlock(subBlock(s)) ^ blkKey;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string name, input byte_t expected, input byte_t actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h got %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // queues the expected bytes and then feeds the block as upstreamReadClk allows
    task automatic sendBlock(input block_t plain);
        block_t expected;
        expected = aesRef(plain, key);
        for (int k = 0; k < `AES_BLOCK_BYTES; k++) begin
            expQ.push_back(expected[`AES_BLOCK_BITS-1-`AES_BYTE_BITS*k -: `AES_BYTE_BITS]);
        end
        for (int k = 0; k < `AES_BLOCK_BYTES; k++) begin
            stallRun = 0;
            while (!upstreamReadClk) begin
                stallRun = stallRun + 1;
                if (stallRun > maxStall) begin
                    maxStall = stallRun;
                end
                @(posedge clk);
                #1;
            end
            inClk = 1'b1;
            inByte = plain[`AES_BLOCK_BITS-1-`AES_BYTE_BITS*k -: `AES_BYTE_BITS];
            @(posedge clk);
            #1;
            inClk = 1'b0;
        end
    endtask

    // block reaches the buffer when upstreamReadClk returns and an idle engine
    // takes it on the following edge
    task automatic waitTaken();
        while (!upstreamReadClk) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic waitDrain();
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    // readMode 0 gives no reads, 1 a read every cycle and 2 random sparse reads
    always begin
        @(posedge clk);
        #1;
        case (readMode)
            2'd1: readClk = 1'b1;
            2'd2: readClk = ($urandom() % 2) == 0;
            default: readClk = 1'b0;
        endcase
    end

    // compare outputs where they are stable
    always @(negedge clk) begin
        if (!rst && outClk) begin
            if (expQ.size() == 0) begin
                failRun("outClk pulsed while no output byte was expected");
            end else begin
                checkValue("outByte", expQ.pop_front(), outByte);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            failRun("timeout: not all expected bytes came out in time");
        end
    end

    initial begin
        void'($urandom(32'h201b605f));
        clk = 1'b0;
        rst = 1'b1;
        inClk = 1'b0;
        inByte = '0;
        key = '0;
        readClk = 1'b0;
        readMode = 2'd0;
        cycles = 0;
        stallRun = 0;
        maxStall = 0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // reads with nothing loaded must stay silent
        readMode = 2'd1;
        repeat (24) @(posedge clk);
        #1;
        checkValue("upstreamReadClk", 8'h01, {7'b0, upstreamReadClk});

        // one known block
        key = 128'h000102030405060708090a0b0c0d0e0f;
        sendBlock(128'h00112233445566778899aabbccddeeff);
        waitDrain();

        // full-rate stream
        key = {$urandom(), $urandom(), $urandom(), $urandom()};
        for (int n = 0; n < 20; n++) begin
            sendBlock({$urandom(), $urandom(), $urandom(), $urandom()});
        end
        waitDrain();

        // slow reader so that the input has to stall
        readMode = 2'd2;
        maxStall = 0;
        for (int n = 0; n < 8; n++) begin
            sendBlock({$urandom(), $urandom(), $urandom(), $urandom()});
        end
        waitDrain();
        if (maxStall <= 2) begin
            failRun("upstreamReadClk did not stay low under back-pressure");
        end

        // key changes while each block is still in the rounds
        readMode = 2'd1;
        for (int n = 0; n < 3; n++) begin
            key = {$urandom(), $urandom(), $urandom(), $urandom()};
            sendBlock({$urandom(), $urandom(), $urandom(), $urandom()});
            waitTaken();
            key = {$urandom(), $urandom(), $urandom(), $urandom()};
            waitDrain();
        end

        repeat (4) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- aesByteStream.f
+incdir+include
hdl/aesTypesPkg.sv
hdl/aesCipherPkg.sv
hdl/blockIf.sv
hdl/bytePacker.sv
hdl/blockBuffer.sv
hdl/cipherEngine.sv
hdl/byteSerializer.sv
hdl/aesByteStream.sv
bench/aesByteStream_chk.sv
bench/aesByteStreamTb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it; a $fatal gives a failing exit status
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module aesByteStreamTb -f aesByteStream.f -o simAes
./obj_dir/simAes
